// File: sim.f
verilog/soc_pkg.sv
verilog/mem_arbiter.sv
verilog/clint_timer.sv
verilog/ram_bridge.sv
verilog/soc_mem_top.sv
tests/tb_soc_mem_top.sv

// File: Makefile
# Verilator build for the soc memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_soc_mem_top
FLIST     ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Regression passed

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# grep decides the exit status, the output is still shown
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tests/golden_vectors.txt
# op M W R I: hex addr, hex data or expected; D: data addr, data exp, inst addr, inst exp
# op N S: decimal wait cycles (S reads mtime before and after); op Q: decimal irq level
Q 0
M 1000 1122334455667788
M 2000 00000000deadbeef
M 2008 cafef00d13579bdf
I 2000 deadbeef
I 2008 13579bdf
W 3000 0123456789abcdef
R 3000 0123456789abcdef
R 1000 1122334455667788
D 1000 1122334455667788 2000 deadbeef
W 3008 fedcba9876543210
D 3008 fedcba9876543210 3008 76543210
W 2004000 0000000000000100
R 2004000 0000000000000100
S 40
N 10
S 100
W 200bff8 0000000000000000
W 2004000 0000000000000014
N 40
Q 0
N 60
Q 1
W 2004000 ffffffffffffffff
N 3
Q 0
R 2004000 ffffffffffffffff
W 1000 aaaa5555aaaa5555
R 1000 aaaa5555aaaa5555
I 1000 aaaa5555
R 2000 00000000deadbeef

// File: tests/tb_soc_mem_top.sv
// replays tests/golden_vectors.txt from the project root; memory model answers in the strobe's next cycle
`timescale 1ns/10ps
`default_nettype none

module tb_soc_mem_top;

    localparam int TICK_DIV   = 4;
    localparam int CLK_PERIOD = 40;
    localparam int RST_CYCLES = 8;

    logic                  clk;
    logic                  i_rst;
    logic                  i_inst_req;
    logic [63:0]           i_inst_addr;
    soc_pkg::data_req_t    data_req;
    logic [31:0]           i_inst_rdata;
    logic [63:0]           i_ram_rdata;
    wire  [31:0]           o_inst_data;
    wire                   o_inst_ok;
    wire  [63:0]           o_data_rdata;
    wire                   o_data_ok;
    wire                   o_ram_rd_ena;
    wire                   o_inst_rd_ena;
    wire  [63:0]           o_ram_addr;
    wire                   o_ram_wr_ena;
    wire  [63:0]           o_ram_wr_addr;
    wire  [63:0]           o_ram_wr_data;
    wire                   o_timer_irq;

    // preload and written words kept apart
    logic [63:0] pre_mem [logic [63:0]];
    logic [63:0] wr_mem [logic [63:0]];
    int          rd_cnt;
    int          inst_cnt;
    int          wr_cnt;
    logic [63:0] last_wr_addr;
    logic [63:0] last_wr_data;
    int          err_cnt;
    int          cycles;
    int          limit;

    logic [7:0]  op_q[$];
    logic [63:0] a_q[$];
    logic [63:0] b_q[$];
    logic [63:0] c_q[$];
    logic [63:0] d_q[$];

    soc_mem_top #(
        .TICK_DIV       (TICK_DIV)
    ) u_dut (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_inst_req     (i_inst_req),
        .i_inst_addr    (i_inst_addr),
        .i_data_req     (data_req),
        .i_inst_rdata   (i_inst_rdata),
        .i_ram_rdata    (i_ram_rdata),
        .o_inst_data    (o_inst_data),
        .o_inst_ok      (o_inst_ok),
        .o_data_rdata   (o_data_rdata),
        .o_data_ok      (o_data_ok),
        .o_ram_rd_ena   (o_ram_rd_ena),
        .o_inst_rd_ena  (o_inst_rd_ena),
        .o_ram_addr     (o_ram_addr),
        .o_ram_wr_ena   (o_ram_wr_ena),
        .o_ram_wr_addr  (o_ram_wr_addr),
        .o_ram_wr_data  (o_ram_wr_data),
        .o_timer_irq    (o_timer_irq)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    // unknown words get a pattern of their whole address
    function automatic logic [63:0] mem_word(input logic [63:0] addr);
        if (wr_mem.exists(addr)) begin
            return wr_mem[addr];
        end
        if (pre_mem.exists(addr)) begin
            return pre_mem[addr];
        end
        return addr ^ 64'h5a5a_5a5a_a5a5_a5a5;
    endfunction

    function automatic logic is_timer(input logic [63:0] addr);
        return (addr == soc_pkg::MTIME_ADDR) || (addr == soc_pkg::MTIMECMP_ADDR);
    endfunction

    // external memory model
    initial begin
        logic [63:0] word;
        i_ram_rdata  = '0;
        i_inst_rdata = '0;
        rd_cnt       = 0;
        inst_cnt     = 0;
        wr_cnt       = 0;
        last_wr_addr = '0;
        last_wr_data = '0;
        forever begin
            @(negedge clk);
            if (o_ram_wr_ena) begin
                wr_mem[o_ram_wr_addr] = o_ram_wr_data;
                last_wr_addr = o_ram_wr_addr;
                last_wr_data = o_ram_wr_data;
                wr_cnt++;
            end
            if (o_ram_rd_ena) begin
                i_ram_rdata = mem_word(o_ram_addr);
                rd_cnt++;
            end
            if (o_inst_rd_ena) begin
                word = mem_word(o_ram_addr);
                i_inst_rdata = word[31:0];
                inst_cnt++;
            end
        end
    end

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic expect_strobes(input int rd0, input int inst0, input int wr0,
                                  input int exp_rd, input int exp_inst, input int exp_wr);
        check_val("o_ram_rd_ena pulses", 64'(rd_cnt - rd0), 64'(exp_rd));
        check_val("o_inst_rd_ena pulses", 64'(inst_cnt - inst0), 64'(exp_inst));
        check_val("o_ram_wr_ena pulses", 64'(wr_cnt - wr0), 64'(exp_wr));
    endtask

    task automatic data_access(input logic wr, input logic [63:0] addr,
                               input logic [63:0] wdata, output logic [63:0] rdata);
        int lat;
        int rd0;
        int inst0;
        int wr0;
        lat   = 0;
        rd0   = rd_cnt;
        inst0 = inst_cnt;
        wr0   = wr_cnt;
        rdata = '0;
        data_req.rd    = ~wr;
        data_req.wr    = wr;
        data_req.addr  = addr;
        data_req.wdata = wdata;
        do begin
            @(negedge clk);
            lat++;
        end while (!o_data_ok && lat < 4);
        data_req.rd = 1'b0;
        data_req.wr = 1'b0;
        if (!o_data_ok) begin
            err_cnt++;
            $display("no data ok pulse within 4 cycles for address 0x%h", addr);
        end else begin
            check_val("o_data_ok latency", 64'(lat), 64'd3);
            rdata = o_data_rdata;
        end
        @(negedge clk);
        if (is_timer(addr)) begin
            expect_strobes(rd0, inst0, wr0, 0, 0, 0);
        end else if (wr) begin
            expect_strobes(rd0, inst0, wr0, 0, 0, 1);
            check_val("o_ram_wr_addr", last_wr_addr, addr);
            check_val("o_ram_wr_data", last_wr_data, wdata);
        end else begin
            expect_strobes(rd0, inst0, wr0, 1, 0, 0);
        end
    endtask

    task automatic inst_access(input logic [63:0] addr, output logic [31:0] idata);
        int lat;
        int rd0;
        int inst0;
        int wr0;
        lat   = 0;
        rd0   = rd_cnt;
        inst0 = inst_cnt;
        wr0   = wr_cnt;
        idata = '0;
        i_inst_req  = 1'b1;
        i_inst_addr = addr;
        do begin
            @(negedge clk);
            lat++;
        end while (!o_inst_ok && lat < 4);
        i_inst_req = 1'b0;
        if (!o_inst_ok) begin
            err_cnt++;
            $display("no instruction ok pulse within 4 cycles for address 0x%h", addr);
        end else begin
            check_val("o_inst_ok latency", 64'(lat), 64'd3);
            idata = o_inst_data;
        end
        @(negedge clk);
        expect_strobes(rd0, inst0, wr0, 0, 1, 0);
    endtask

    // both raised together and data is served first
    task automatic dual_access(input logic [63:0] daddr, input logic [63:0] dexp,
                               input logic [63:0] iaddr, input logic [63:0] iexp);
        int n;
        int dlat;
        int ilat;
        n    = 0;
        dlat = 0;
        ilat = 0;
        data_req.rd    = 1'b1;
        data_req.wr    = 1'b0;
        data_req.addr  = daddr;
        data_req.wdata = '0;
        i_inst_req     = 1'b1;
        i_inst_addr    = iaddr;
        while ((dlat == 0 || ilat == 0) && n < 10) begin
            @(negedge clk);
            n++;
            if (o_data_ok) begin
                dlat = n;
                data_req.rd = 1'b0;
                check_val("o_data_rdata", o_data_rdata, dexp);
            end
            if (o_inst_ok) begin
                ilat = n;
                i_inst_req = 1'b0;
                check_val("o_inst_data", {32'd0, o_inst_data}, iexp);
            end
        end
        data_req.rd = 1'b0;
        i_inst_req  = 1'b0;
        if (dlat == 0 || ilat == 0) begin
            err_cnt++;
            $display("concurrent requests were not both answered within 10 cycles");
        end else begin
            check_val("o_data_ok latency", 64'(dlat), 64'd3);
            check_val("o_inst_ok latency", 64'(ilat), 64'd6);
        end
        @(negedge clk);
    endtask

    initial begin
        int          fd;
        int          r;
        int          waits;
        logic [7:0]  op;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] c;
        logic [63:0] d;
        logic [63:0] rval;
        logic [63:0] t1;
        logic [31:0] idata;
        logic [8*256-1:0] line;
        void'($urandom(50976));
        err_cnt     = 0;
        cycles      = 0;
        limit       = 0;
        waits       = 0;
        i_rst       = 1'b1;
        i_inst_req  = 1'b0;
        i_inst_addr = '0;
        data_req    = '0;

        fd = $fopen("tests/golden_vectors.txt", "r");
        if (fd == 0) begin
            err_cnt++;
            $display("could not open tests/golden_vectors.txt");
        end else begin
            while (!$feof(fd)) begin
                a = '0;
                b = '0;
                c = '0;
                d = '0;
                r = $fscanf(fd, " %c", op);
                if (r != 1) begin
                    break;
                end
                if (op == "#") begin
                    r = $fgets(line, fd);
                end else if (op == "M") begin
                    r = $fscanf(fd, "%h %h", a, b);
                    pre_mem[a] = b;
                end else begin
                    if (op == "N" || op == "S" || op == "Q") begin
                        r = $fscanf(fd, "%d", a);
                    end else if (op == "D") begin
                        r = $fscanf(fd, "%h %h %h %h", a, b, c, d);
                    end else begin
                        r = $fscanf(fd, "%h %h", a, b);
                    end
                    if (op == "N" || op == "S") begin
                        waits += int'(a);
                    end
                    op_q.push_back(op);
                    a_q.push_back(a);
                    b_q.push_back(b);
                    c_q.push_back(c);
                    d_q.push_back(d);
                end
            end
            $fclose(fd);
        end
        limit = op_q.size() * 8 + waits + 200;

        repeat (RST_CYCLES) @(negedge clk);
        i_rst = 1'b0;
        @(negedge clk);

        foreach (op_q[i]) begin
            // idle gap between operations
            repeat ($urandom % 4) @(negedge clk);
            case (op_q[i])
                "W": data_access(1'b1, a_q[i], b_q[i], rval);
                "R": begin
                    data_access(1'b0, a_q[i], '0, rval);
                    check_val("o_data_rdata", rval, b_q[i]);
                end
                "I": begin
                    inst_access(a_q[i], idata);
                    check_val("o_inst_data", {32'd0, idata}, b_q[i]);
                end
                "D": dual_access(a_q[i], b_q[i], c_q[i], d_q[i]);
                "N": repeat (int'(a_q[i])) @(negedge clk);
                "S": begin
                    data_access(1'b0, soc_pkg::MTIME_ADDR, '0, t1);
                    repeat (int'(a_q[i])) @(negedge clk);
                    data_access(1'b0, soc_pkg::MTIME_ADDR, '0, rval);
                    check_val("mtime non-decreasing", {63'd0, rval >= t1}, 64'd1);
                    check_val("mtime advance",
                              {63'd0, (rval - t1) >= 64'(int'(a_q[i]) / TICK_DIV - 1)}, 64'd1);
                end
                "Q": check_val("o_timer_irq", {63'd0, o_timer_irq}, a_q[i]);
                default: begin
                    err_cnt++;
                    $display("unknown operation code in golden file: %c", op_q[i]);
                end
            endcase
        end

        $display("operations: %0d, errors: %0d", op_q.size(), err_cnt);
        if (err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/soc_mem_top.sv
// memory side of the soc without core or caches; requesters hold their level until ok
`timescale 1ns/10ps
`default_nettype none

module soc_mem_top #(
    parameter int TICK_DIV = 4
) (
    input  wire                         clk,
    input  wire                         i_rst,
    input  wire                         i_inst_req,
    input  wire  [soc_pkg::ADDR_W-1:0]  i_inst_addr,
    input  soc_pkg::data_req_t          i_data_req,
    input  wire  [soc_pkg::INST_W-1:0]  i_inst_rdata,
    input  wire  [soc_pkg::DATA_W-1:0]  i_ram_rdata,
    output wire  [soc_pkg::INST_W-1:0]  o_inst_data,
    output wire                         o_inst_ok,
    output wire  [soc_pkg::DATA_W-1:0]  o_data_rdata,
    output wire                         o_data_ok,
    output wire                         o_ram_rd_ena,
    output wire                         o_inst_rd_ena,
    output wire  [soc_pkg::ADDR_W-1:0]  o_ram_addr,
    output wire                         o_ram_wr_ena,
    output wire  [soc_pkg::ADDR_W-1:0]  o_ram_wr_addr,
    output wire  [soc_pkg::DATA_W-1:0]  o_ram_wr_data,
    output wire                         o_timer_irq
);

    soc_pkg::mem_cmd_t           mem_cmd;
    soc_pkg::tmr_cmd_t           tmr_cmd;
    wire [soc_pkg::DATA_W-1:0]   ram_rdata64;
    wire [soc_pkg::INST_W-1:0]   ram_rdata32;
    wire                         ram_valid;
    wire [soc_pkg::DATA_W-1:0]   tmr_rdata;
    wire                         tmr_valid;

    mem_arbiter u_arbiter (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_inst_req     (i_inst_req),
        .i_inst_addr    (i_inst_addr),
        .i_data_req     (i_data_req),
        .i_ram_rdata64  (ram_rdata64),
        .i_ram_rdata32  (ram_rdata32),
        .i_ram_valid    (ram_valid),
        .i_tmr_rdata    (tmr_rdata),
        .i_tmr_valid    (tmr_valid),
        .o_mem_cmd      (mem_cmd),
        .o_tmr_cmd      (tmr_cmd),
        .o_inst_data    (o_inst_data),
        .o_inst_ok      (o_inst_ok),
        .o_data_rdata   (o_data_rdata),
        .o_data_ok      (o_data_ok)
    );

    // external ram pins
    ram_bridge u_ram (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_cmd          (mem_cmd),
        .i_inst_rdata   (i_inst_rdata),
        .i_ram_rdata    (i_ram_rdata),
        .o_ram_rd_ena   (o_ram_rd_ena),
        .o_inst_rd_ena  (o_inst_rd_ena),
        .o_ram_addr     (o_ram_addr),
        .o_ram_wr_ena   (o_ram_wr_ena),
        .o_ram_wr_addr  (o_ram_wr_addr),
        .o_ram_wr_data  (o_ram_wr_data),
        .o_rdata64      (ram_rdata64),
        .o_rdata32      (ram_rdata32),
        .o_resp_valid   (ram_valid)
    );

    clint_timer #(
        .TICK_DIV       (TICK_DIV)
    ) u_timer (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_cmd          (tmr_cmd),
        .o_rdata        (tmr_rdata),
        .o_rd_valid     (tmr_valid),
        .o_irq          (o_timer_irq)
    );

endmodule

`default_nettype wire

// File: verilog/ram_bridge.sv
// external memory must return read data in the cycle after its read strobe
`timescale 1ns/10ps
`default_nettype none

module ram_bridge (
    input  wire                         clk,
    input  wire                         i_rst,
    input  soc_pkg::mem_cmd_t           i_cmd,
    input  wire  [soc_pkg::INST_W-1:0]  i_inst_rdata,
    input  wire  [soc_pkg::DATA_W-1:0]  i_ram_rdata,
    output logic                        o_ram_rd_ena,
    output logic                        o_inst_rd_ena,
    output logic [soc_pkg::ADDR_W-1:0]  o_ram_addr,
    output logic                        o_ram_wr_ena,
    output logic [soc_pkg::ADDR_W-1:0]  o_ram_wr_addr,
    output logic [soc_pkg::DATA_W-1:0]  o_ram_wr_data,
    output logic [soc_pkg::DATA_W-1:0]  o_rdata64,
    output logic [soc_pkg::INST_W-1:0]  o_rdata32,
    output logic                        o_resp_valid
);

    // strobes delayed by one, mark the cycle the memory answers
    logic                        rd64_d;
    logic                        rd32_d;
    logic                        wr_d;
    logic [soc_pkg::DATA_W-1:0]  rdata64_q;
    logic [soc_pkg::INST_W-1:0]  rdata32_q;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_ram_rd_ena  <= 1'b0;
            o_inst_rd_ena <= 1'b0;
            o_ram_wr_ena  <= 1'b0;
            rd64_d        <= 1'b0;
            rd32_d        <= 1'b0;
            wr_d          <= 1'b0;
        end else begin
            o_ram_rd_ena  <= i_cmd.ram_rd;
            o_inst_rd_ena <= i_cmd.inst_rd;
            o_ram_wr_ena  <= i_cmd.wr;
            rd64_d        <= o_ram_rd_ena;
            rd32_d        <= o_inst_rd_ena;
            wr_d          <= o_ram_wr_ena;
        end
    end

    // address and data pins only move on a new access
    always_ff @(posedge clk) begin
        if (i_cmd.ram_rd || i_cmd.inst_rd) begin
            o_ram_addr <= i_cmd.addr;
        end
        if (i_cmd.wr) begin
            o_ram_wr_addr <= i_cmd.addr;
            o_ram_wr_data <= i_cmd.wdata;
        end
    end

    // holding registers keep the last word after the answer cycle
    always_ff @(posedge clk) begin
        if (rd64_d) begin
            rdata64_q <= i_ram_rdata;
        end
        if (rd32_d) begin
            rdata32_q <= i_inst_rdata;
        end
    end

    assign o_rdata64    = rd64_d ? i_ram_rdata : rdata64_q;
    assign o_rdata32    = rd32_d ? i_inst_rdata : rdata32_q;
    // writes answer too, so every ram access looks the same upstream
    assign o_resp_valid = rd64_d | rd32_d | wr_d;

endmodule

`default_nettype wire

// File: verilog/clint_timer.sv
// mtime/mtimecmp only, full 64-bit accesses; TICK_DIV must be 1 or more
`timescale 1ns/10ps
`default_nettype none

module clint_timer #(
    parameter int TICK_DIV = 4
) (
    input  wire                         clk,
    input  wire                         i_rst,
    input  soc_pkg::tmr_cmd_t           i_cmd,
    output logic [soc_pkg::DATA_W-1:0]  o_rdata,
    output logic                        o_rd_valid,
    output logic                        o_irq
);

    localparam int PRE_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [PRE_W-1:0]            pre_cnt;
    logic                        tick;
    logic [soc_pkg::DATA_W-1:0]  mtime;
    logic [soc_pkg::DATA_W-1:0]  mtimecmp;

    assign tick = (pre_cnt == PRE_W'(TICK_DIV - 1));

    // prescaler and mtime, a write to mtime restarts the prescale period
    always_ff @(posedge clk) begin
        if (i_rst) begin
            pre_cnt <= '0;
            mtime   <= '0;
        end else if (i_cmd.wr && !i_cmd.sel) begin
            pre_cnt <= '0;
            mtime   <= i_cmd.wdata;
        end else if (tick) begin
            pre_cnt <= '0;
            mtime   <= mtime + 1'b1;
        end else begin
            pre_cnt <= pre_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            mtimecmp <= '1;
        end else if (i_cmd.wr && i_cmd.sel) begin
            mtimecmp <= i_cmd.wdata;
        end
    end

    // register reads
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_rd_valid <= 1'b0;
        end else begin
            o_rd_valid <= i_cmd.rd;
        end
    end

    always_ff @(posedge clk) begin
        if (i_cmd.rd) begin
            o_rdata <= i_cmd.sel ? mtimecmp : mtime;
        end
    end

    // level interrupt, follows register writes one edge later
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_irq <= 1'b0;
        end else begin
            o_irq <= (mtime >= mtimecmp);
        end
    end

endmodule

`default_nettype wire

// File: verilog/mem_arbiter.sv
// one access at a time, data wins over fetch; ok pulses 2 cycles after the sampling edge
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter (
    input  wire                            clk,
    input  wire                            i_rst,
    input  wire                            i_inst_req,
    input  wire  [soc_pkg::ADDR_W-1:0]     i_inst_addr,
    input  soc_pkg::data_req_t             i_data_req,
    input  wire  [soc_pkg::DATA_W-1:0]     i_ram_rdata64,
    input  wire  [soc_pkg::INST_W-1:0]     i_ram_rdata32,
    input  wire                            i_ram_valid,
    input  wire  [soc_pkg::DATA_W-1:0]     i_tmr_rdata,
    input  wire                            i_tmr_valid,
    output soc_pkg::mem_cmd_t              o_mem_cmd,
    output soc_pkg::tmr_cmd_t              o_tmr_cmd,
    output logic [soc_pkg::INST_W-1:0]     o_inst_data,
    output logic                           o_inst_ok,
    output logic [soc_pkg::DATA_W-1:0]     o_data_rdata,
    output logic                           o_data_ok
);

    soc_pkg::arb_state_t state;

    // latched winner
    logic                        own_data;
    logic                        req_wr;
    logic                        req_tmr;
    logic                        req_sel;
    logic [soc_pkg::ADDR_W-1:0]  req_addr;
    logic [soc_pkg::DATA_W-1:0]  req_wdata;

    logic [soc_pkg::DATA_W-1:0]  tmr_rdata_q;
    logic                        data_pending;
    logic                        hit_mtime;
    logic                        hit_mtimecmp;
    logic                        in_access;

    assign data_pending = i_data_req.rd | i_data_req.wr;
    assign hit_mtime    = (i_data_req.addr == soc_pkg::MTIME_ADDR);
    assign hit_mtimecmp = (i_data_req.addr == soc_pkg::MTIMECMP_ADDR);
    assign in_access    = (state == soc_pkg::ACCESS);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state     <= soc_pkg::IDLE;
            own_data  <= 1'b0;
            req_wr    <= 1'b0;
            req_tmr   <= 1'b0;
            req_sel   <= 1'b0;
            o_inst_ok <= 1'b0;
            o_data_ok <= 1'b0;
        end else begin
            o_inst_ok <= 1'b0;
            o_data_ok <= 1'b0;
            case (state)
                soc_pkg::IDLE: begin
                    if (data_pending) begin
                        own_data <= 1'b1;
                        req_wr   <= i_data_req.wr;
                        req_tmr  <= hit_mtime | hit_mtimecmp;
                        req_sel  <= hit_mtimecmp;
                        state    <= soc_pkg::ACCESS;
                    end else if (i_inst_req) begin
                        // fetches always go to ram
                        own_data <= 1'b0;
                        req_wr   <= 1'b0;
                        req_tmr  <= 1'b0;
                        req_sel  <= 1'b0;
                        state    <= soc_pkg::ACCESS;
                    end
                end
                soc_pkg::ACCESS: begin
                    state <= soc_pkg::RESPOND;
                end
                soc_pkg::RESPOND: begin
                    o_data_ok <= own_data;
                    o_inst_ok <= ~own_data;
                    state     <= soc_pkg::IDLE;
                end
                default: begin
                    state <= soc_pkg::IDLE;
                end
            endcase
        end
    end

    // address and write data of the winner
    always_ff @(posedge clk) begin
        if (state == soc_pkg::IDLE) begin
            if (data_pending) begin
                req_addr  <= i_data_req.addr;
                req_wdata <= i_data_req.wdata;
            end else if (i_inst_req) begin
                req_addr  <= i_inst_addr;
                req_wdata <= '0;
            end
        end
    end

    // timer answers during RESPOND, hold it for the ok cycle
    always_ff @(posedge clk) begin
        if (i_tmr_valid) begin
            tmr_rdata_q <= i_tmr_rdata;
        end
    end

    // one-cycle commands while in ACCESS
    always_comb begin
        o_mem_cmd.ram_rd  = in_access & own_data & ~req_wr & ~req_tmr;
        o_mem_cmd.inst_rd = in_access & ~own_data;
        o_mem_cmd.wr      = in_access & own_data & req_wr & ~req_tmr;
        o_mem_cmd.addr    = req_addr;
        o_mem_cmd.wdata   = req_wdata;
        o_tmr_cmd.rd      = in_access & req_tmr & ~req_wr;
        o_tmr_cmd.wr      = in_access & req_tmr & req_wr;
        o_tmr_cmd.sel     = req_sel;
        o_tmr_cmd.wdata   = req_wdata;
    end

    // ram data arrives in the ok cycle itself
    assign o_data_rdata = i_ram_valid ? i_ram_rdata64 : tmr_rdata_q;
    assign o_inst_data  = i_ram_rdata32;

endmodule

`default_nettype wire

// File: verilog/soc_pkg.sv
// shared widths, timer register addresses and command structs; all accesses are full 64-bit words
`default_nettype none

package soc_pkg;

    // bus widths
    localparam int ADDR_W = 64;
    localparam int DATA_W = 64;
    localparam int INST_W = 32;

    // core-local timer registers, anything else maps to external ram
    localparam logic [ADDR_W-1:0] MTIME_ADDR    = 64'h0000_0000_0200_BFF8;
    localparam logic [ADDR_W-1:0] MTIMECMP_ADDR = 64'h0000_0000_0200_4000;

    // data requester, rd/wr are levels held until ok
    typedef struct packed {
        logic              rd;
        logic              wr;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } data_req_t;

    // arbiter to ram bridge, strobes are single-cycle
    typedef struct packed {
        logic              ram_rd;
        logic              inst_rd;
        logic              wr;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } mem_cmd_t;

    // arbiter to timer, sel 0 is mtime and 1 is mtimecmp
    typedef struct packed {
        logic              rd;
        logic              wr;
        logic              sel;
        logic [DATA_W-1:0] wdata;
    } tmr_cmd_t;

    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        ACCESS  = 2'd1,
        RESPOND = 2'd2
    } arb_state_t;

endpackage

`default_nettype wire
